// ==== list.f ====
verilog/hist_pkg.sv
verilog/sample_binner.sv
verilog/histogram_ram.sv
verilog/bin_accumulator.sv
verilog/bin_readout.sv
verilog/spectrum_top.sv
verif/spectrum_checker.sv
verif/tb_spectrum.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build with Verilator, run, and pass only when the testbench reports a pass
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --top-module tb_spectrum -f list.f -o sim_spectrum &&
  ./obj_dir/sim_spectrum | tee /dev/stderr | grep -qx "STATUS: PASS" &&
  echo "simulation passed" && exit 0 ||
  { echo "simulation failed"; exit 1; }

// ==== verif/tb_spectrum.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_spectrum
  import hist_pkg::*;
();

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 4;
  localparam int BIN_SHIFT    = 10;
  // a request held in the binner plus one inside the accumulator
  localparam int DRAIN_CYCLES = 8;
  localparam logic [31:0]                LCG_SEED  = 32'h8e70e67e;
  localparam logic signed [SAMPLE_W-1:0] MIN_LEVEL = 16'sh8000;

  typedef enum logic [1:0] {ACT_STREAM, ACT_CLEAR, ACT_DUMP} action_e;

  typedef struct packed {
    action_e                    act;
    logic signed [SAMPLE_W-1:0] sample;
    logic signed [SAMPLE_W-1:0] thr;
    logic [15:0]                reps;
  } stim_row_t;

  logic                       aclk;
  logic                       aresetn;
  sample_t                    in_sample;
  logic                       in_valid;
  logic                       in_ready;
  logic signed [SAMPLE_W-1:0] threshold;
  logic                       clear;
  logic                       dump;
  bin_beat_t                  out_beat;
  logic                       out_valid;
  logic                       out_ready;
  logic                       busy;
  logic                       sweeping;
  logic                       end_of_test;
  int                         check_count;
  int                         error_count;
  logic [31:0]                rng;
  stim_row_t                  stim_q [$];

  always #(CLK_PERIOD / 2) aclk = ~aclk;

  spectrum_top #(.BIN_SHIFT(BIN_SHIFT)) u_spectrum_top (.*);

  spectrum_checker #(.BIN_SHIFT(BIN_SHIFT)) u_checker (.*);

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic next_cycle(output logic took);
    @(negedge aclk);
    took = in_valid && in_ready;
    @(posedge aclk);
    #2;
    rng       = lcg_next(rng);
    // sink ready about three cycles in four
    out_ready = (rng[31:30] != 2'b00);
  endtask

  task automatic wait_cycles(input int n);
    logic took;
    repeat (n)
      next_cycle(took);
  endtask

  task automatic send_sample(input logic signed [SAMPLE_W-1:0] s,
                             input logic signed [SAMPLE_W-1:0] thr);
    logic took;
    threshold = thr;
    // idle gap before roughly one sample in four
    if (rng[27:26] == 2'b00)
      next_cycle(took);
    in_sample.value = s;
    in_valid        = 1'b1;
    took            = 1'b0;
    while (!took)
      next_cycle(took);
    in_valid = 1'b0;
  endtask

  task automatic issue_clear();
    logic took;
    wait_cycles(DRAIN_CYCLES);
    clear = 1'b1;
    next_cycle(took);
    clear = 1'b0;
  endtask

  task automatic issue_dump();
    logic took;
    wait_cycles(DRAIN_CYCLES);
    while (sweeping)
      next_cycle(took);
    dump = 1'b1;
    next_cycle(took);
    dump = 1'b0;
    // second request lands while busy
    wait_cycles(3);
    dump = 1'b1;
    next_cycle(took);
    dump = 1'b0;
    while (busy)
      next_cycle(took);
  endtask

  task automatic add_row(input action_e act, input logic signed [SAMPLE_W-1:0] s,
                         input logic signed [SAMPLE_W-1:0] thr, input logic [15:0] reps);
    stim_row_t row;
    row.act    = act;
    row.sample = s;
    row.thr    = thr;
    row.reps   = reps;
    stim_q.push_back(row);
  endtask

  task automatic build_table();
    add_row(ACT_DUMP, '0, '0, '0);
    // spread over the signed range
    add_row(ACT_STREAM, MIN_LEVEL, MIN_LEVEL, 16'd3);
    add_row(ACT_STREAM, -16'sd20000, MIN_LEVEL, 16'd2);
    add_row(ACT_STREAM, -16'sd1, MIN_LEVEL, 16'd1);
    add_row(ACT_STREAM, 16'sd0, MIN_LEVEL, 16'd2);
    add_row(ACT_STREAM, 16'sd1000, MIN_LEVEL, 16'd3);
    add_row(ACT_STREAM, 16'sd16384, MIN_LEVEL, 16'd2);
    add_row(ACT_STREAM, 16'sd32767, MIN_LEVEL, 16'd4);
    add_row(ACT_DUMP, '0, '0, '0);
    // below and exactly at the threshold
    add_row(ACT_STREAM, 16'sd4999, 16'sd5000, 16'd3);
    add_row(ACT_STREAM, 16'sd5000, 16'sd5000, 16'd2);
    add_row(ACT_STREAM, -16'sd30000, 16'sd5000, 16'd2);
    add_row(ACT_DUMP, '0, '0, '0);
    // bin 40 saturates, bins 39 and 41 stay small
    add_row(ACT_STREAM, 16'sd8000, MIN_LEVEL, 16'd5);
    add_row(ACT_STREAM, 16'sd9000, MIN_LEVEL, 16'd4100);
    add_row(ACT_STREAM, 16'sd10000, MIN_LEVEL, 16'd5);
    add_row(ACT_DUMP, '0, '0, '0);
    add_row(ACT_CLEAR, '0, '0, '0);
    add_row(ACT_DUMP, '0, '0, '0);
    add_row(ACT_CLEAR, '0, '0, '0);
    // these stall behind the sweep, then count from zero
    add_row(ACT_STREAM, 16'sd300, MIN_LEVEL, 16'd4);
    add_row(ACT_DUMP, '0, '0, '0);
  endtask

  initial
  begin
    aclk        = 1'b0;
    aresetn     = 1'b0;
    in_sample   = '0;
    in_valid    = 1'b0;
    threshold   = MIN_LEVEL;
    clear       = 1'b0;
    dump        = 1'b0;
    out_ready   = 1'b0;
    end_of_test = 1'b0;
    rng         = LCG_SEED;
    build_table();
    repeat (RESET_CYCLES)
      @(posedge aclk);
    #2;
    aresetn = 1'b1;
    foreach (stim_q[i])
    begin
      case (stim_q[i].act)
        ACT_STREAM:
          repeat (stim_q[i].reps)
            send_sample(stim_q[i].sample, stim_q[i].thr);
        ACT_CLEAR:
          issue_clear();
        default:
          issue_dump();
      endcase
    end
    end_of_test = 1'b1;
    wait_cycles(2);
    $display("summary: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0 && check_count > 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

  // watchdog sized from the table
  initial
  begin
    int samples;
    int events;
    int limit_cycles;
    samples = 0;
    events  = 0;
    #1;
    foreach (stim_q[i])
    begin
      if (stim_q[i].act == ACT_STREAM)
        samples += int'(stim_q[i].reps);
      else
        events += 1;
    end
    limit_cycles = (RESET_CYCLES + 3 * samples + 70 * events) * 3 / 2;
    #(limit_cycles * CLK_PERIOD);
    $display("timeout: run still going after %0d cycles, %0d checks, %0d errors",
             limit_cycles, check_count, error_count);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/spectrum_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module spectrum_checker
  import hist_pkg::*;
#(
  parameter int BIN_SHIFT = 10
)
(
  input  logic                       aclk,
  input  logic                       aresetn,
  input  sample_t                    in_sample,
  input  logic                       in_valid,
  input  logic                       in_ready,
  input  logic signed [SAMPLE_W-1:0] threshold,
  input  logic                       clear,
  input  logic                       dump,
  input  logic                       sweeping,
  input  bin_beat_t                  out_beat,
  input  logic                       out_valid,
  input  logic                       out_ready,
  input  logic                       busy,
  input  logic                       end_of_test,
  output int                         check_count,
  output int                         error_count
);

  localparam int COUNT_MAX = (1 << COUNT_W) - 1;

  int   model [NUM_BINS];
  int   next_bin;
  int   sweep_hits;
  logic dump_open;
  logic first_cycle;
  logic end_seen;

  // signed sample moved up by half the range, scaled down, clamped to the top bin
  function automatic int bin_of(input logic signed [SAMPLE_W-1:0] s);
    int b;
    b = (int'(s) + (1 << (SAMPLE_W - 1))) >> BIN_SHIFT;
    return (b > NUM_BINS - 1) ? NUM_BINS - 1 : b;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    if (exp !== act)
    begin
      error_count++;
      $display("ERR %s expected 0x%0h actual 0x%0h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic note_failure(input string what);
    error_count++;
    $display("%s at %0t", what, $time);
  endtask

  always @(posedge aclk)
  begin
    int b;
    if (!aresetn)
    begin
      foreach (model[i])
        model[i] = 0;
      next_bin    = 0;
      sweep_hits  = 0;
      dump_open   = 1'b0;
      first_cycle = 1'b1;
      end_seen    = 1'b0;
    end
    else
    begin
      if (first_cycle)
      begin
        first_cycle = 1'b0;
        check_val("in_ready", 32'd1, 32'(in_ready));
        check_val("out_valid", 32'd0, 32'(out_valid));
        check_val("busy", 32'd0, 32'(busy));
        check_val("sweeping", 32'd1, 32'(sweeping));
      end
      if (in_valid && in_ready && in_sample.value >= threshold)
      begin
        b = bin_of(in_sample.value);
        model[b] = (model[b] < COUNT_MAX) ? model[b] + 1 : model[b];
        // only the binner's one register can fill while the RAM is swept
        if (sweeping)
        begin
          sweep_hits++;
          if (sweep_hits > 1)
            note_failure("a second sample was accepted during the zero sweep");
        end
      end
      if (clear && !sweeping)
      begin
        foreach (model[i])
          model[i] = 0;
        sweep_hits = 0;
      end
      if (dump && !busy)
      begin
        if (dump_open)
          note_failure($sformatf("new dump started with %0d beats missing", NUM_BINS - next_bin));
        dump_open = 1'b1;
        next_bin  = 0;
      end
      if (out_valid && out_ready)
      begin
        if (!dump_open)
          note_failure($sformatf("beat for bin %0d came with no dump pending", out_beat.bin));
        else
        begin
          if (int'(out_beat.bin) != next_bin)
          begin
            note_failure($sformatf("beat out of order, expected bin %0d but got bin %0d",
                                   next_bin, out_beat.bin));
            next_bin = int'(out_beat.bin);
          end
          check_val("out_beat.count", 32'(model[next_bin]), 32'(out_beat.count));
          check_val("out_beat.last", 32'(next_bin == NUM_BINS - 1), 32'(out_beat.last));
          next_bin++;
          dump_open = (next_bin < NUM_BINS);
        end
      end
      if (end_of_test && !end_seen)
      begin
        end_seen = 1'b1;
        if (dump_open)
          note_failure($sformatf("dump ended with %0d beats missing", NUM_BINS - next_bin));
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/spectrum_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module spectrum_top
  import hist_pkg::*;
#(
  parameter int BIN_SHIFT = 10
)
(
  input  logic                       aclk,
  input  logic                       aresetn,
  input  sample_t                    in_sample,
  input  logic                       in_valid,
  output logic                       in_ready,
  input  logic signed [SAMPLE_W-1:0] threshold,
  input  logic                       clear,
  input  logic                       dump,
  output bin_beat_t                  out_beat,
  output logic                       out_valid,
  input  logic                       out_ready,
  output logic                       busy,
  output logic                       sweeping
);

  bin_req_t           req;
  logic               req_valid;
  logic               req_ready;
  ram_port_t          port_a;
  ram_port_t          port_b;
  logic [COUNT_W-1:0] rd_a;
  logic [COUNT_W-1:0] rd_b;

  sample_binner #(
    .BIN_SHIFT (BIN_SHIFT)
  ) u_sample_binner (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .in_sample (in_sample),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .threshold (threshold),
    .req       (req),
    .req_valid (req_valid),
    .req_ready (req_ready)
  );

  bin_accumulator u_bin_accumulator (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .clear     (clear),
    .req       (req),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .port_a    (port_a),
    .rd_a      (rd_a),
    .sweeping  (sweeping)
  );

  histogram_ram u_histogram_ram (
    .aclk   (aclk),
    .port_a (port_a),
    .rd_a   (rd_a),
    .port_b (port_b),
    .rd_b   (rd_b)
  );

  bin_readout u_bin_readout (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .dump      (dump),
    .port_b    (port_b),
    .rd_b      (rd_b),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .busy      (busy)
  );

endmodule

`default_nettype wire

// ==== verilog/bin_readout.sv ====
`timescale 1ns/100ps
`default_nettype none

module bin_readout
  import hist_pkg::*;
(
  input  logic               aclk,
  input  logic               aresetn,
  input  logic               dump,
  output ram_port_t          port_b,
  input  logic [COUNT_W-1:0] rd_b,
  output bin_beat_t          out_beat,
  output logic               out_valid,
  input  logic               out_ready,
  output logic               busy
);

  typedef enum logic [1:0] {
    PH_ADDR,
    PH_CAPTURE,
    PH_PRESENT
  } phase_e;

  phase_e           phase;
  logic [BIN_W-1:0] bin_cnt;
  logic [BIN_W-1:0] next_cnt;
  logic             xfer;

  assign out_valid = (phase == PH_PRESENT);
  assign busy      = (phase != PH_ADDR);
  assign xfer      = out_valid && out_ready;

  // the next address goes out in the transfer cycle itself
  assign next_cnt = xfer ? bin_cnt + BIN_W'(1) : bin_cnt;

  always_comb
  begin
    port_b.addr  = next_cnt;
    port_b.wdata = '0;
    port_b.we    = 1'b0;
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      phase   <= PH_ADDR;
      bin_cnt <= '0;
    end
    else
    begin
      // wraps back to bin 0 after the last beat
      bin_cnt <= next_cnt;
      case (phase)
        PH_ADDR:
        begin
          if (dump)
            phase <= PH_CAPTURE;
        end
        PH_CAPTURE:
        begin
          phase <= PH_PRESENT;
        end
        PH_PRESENT:
        begin
          if (xfer)
            phase <= out_beat.last ? PH_ADDR : PH_CAPTURE;
        end
        default:
        begin
          phase <= PH_ADDR;
        end
      endcase
    end
  end

  always_ff @(posedge aclk)
  begin
    if (phase == PH_CAPTURE)
    begin
      out_beat.bin   <= bin_cnt;
      out_beat.count <= rd_b;
      out_beat.last  <= (bin_cnt == BIN_W'(NUM_BINS - 1));
    end
  end

  a_beat_hold: assert property (
    @(posedge aclk) disable iff (!aresetn)
    out_valid && !out_ready |=> out_valid && $stable(out_beat)
  );

endmodule

`default_nettype wire

// ==== verilog/bin_accumulator.sv ====
`timescale 1ns/100ps
`default_nettype none

module bin_accumulator
  import hist_pkg::*;
(
  input  logic               aclk,
  input  logic               aresetn,
  input  logic               clear,
  input  bin_req_t           req,
  input  logic               req_valid,
  output logic               req_ready,
  output ram_port_t          port_a,
  input  logic [COUNT_W-1:0] rd_a,
  output logic               sweeping
);

  typedef enum logic [1:0] {
    ST_SWEEP,
    ST_IDLE,
    ST_READ,
    ST_WRITE
  } acc_state_e;

  acc_state_e         state;
  logic [BIN_W-1:0]   addr_q;
  logic [COUNT_W-1:0] inc_count;
  logic               saturated;

  assign sweeping  = (state == ST_SWEEP);
  assign inc_count = rd_a + COUNT_W'(1);
  assign saturated = &rd_a;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      state     <= ST_SWEEP;
      addr_q    <= '0;
      req_ready <= 1'b0;
    end
    else if (clear && state != ST_SWEEP)
    begin
      // restart the zero sweep, dropping any update in flight
      state     <= ST_SWEEP;
      addr_q    <= '0;
      req_ready <= 1'b0;
    end
    else
    begin
      case (state)
        ST_SWEEP:
        begin
          addr_q <= addr_q + BIN_W'(1);
          if (&addr_q)
          begin
            state     <= ST_IDLE;
            req_ready <= 1'b1;
          end
        end
        ST_IDLE:
        begin
          if (req_valid && req_ready)
          begin
            addr_q    <= req.bin;
            req_ready <= 1'b0;
            state     <= ST_READ;
          end
        end
        ST_READ:
        begin
          state <= ST_WRITE;
        end
        ST_WRITE:
        begin
          state     <= ST_IDLE;
          req_ready <= 1'b1;
        end
        default:
        begin
          state <= ST_SWEEP;
        end
      endcase
    end
  end

  always_comb
  begin
    port_a.addr  = addr_q;
    port_a.wdata = '0;
    port_a.we    = 1'b0;
    case (state)
      ST_SWEEP:
      begin
        port_a.we = 1'b1;
      end
      ST_WRITE:
      begin
        // a full count stays put
        port_a.wdata = inc_count;
        port_a.we    = !saturated;
      end
      default:
      begin
        port_a.we = 1'b0;
      end
    endcase
  end

  // an update write always follows the read of the same bin
  a_write_phase: assert property (
    @(posedge aclk) disable iff (!aresetn)
    port_a.we |-> sweeping || (state == ST_WRITE && $past(state) == ST_READ)
  );

  a_no_ready_in_sweep: assert property (
    @(posedge aclk) disable iff (!aresetn)
    sweeping |-> !req_ready
  );

endmodule

`default_nettype wire

// ==== verilog/histogram_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module histogram_ram
  import hist_pkg::*;
(
  input  logic               aclk,
  input  ram_port_t          port_a,
  output logic [COUNT_W-1:0] rd_a,
  input  ram_port_t          port_b,
  output logic [COUNT_W-1:0] rd_b
);

  logic [COUNT_W-1:0] mem [NUM_BINS];

  // port A reads the old count before the write lands
  always_ff @(posedge aclk)
  begin
    rd_a <= mem[port_a.addr];
    if (port_a.we)
      mem[port_a.addr] <= port_a.wdata;
  end

  // port B only reads
  always_ff @(posedge aclk)
  begin
    rd_b <= mem[port_b.addr];
  end

endmodule

`default_nettype wire

// ==== verilog/sample_binner.sv ====
`timescale 1ns/100ps
`default_nettype none

module sample_binner
  import hist_pkg::*;
#(
  parameter int BIN_SHIFT = 10
)
(
  input  logic                       aclk,
  input  logic                       aresetn,
  input  sample_t                    in_sample,
  input  logic                       in_valid,
  output logic                       in_ready,
  input  logic signed [SAMPLE_W-1:0] threshold,
  output bin_req_t                   req,
  output logic                       req_valid,
  input  logic                       req_ready
);

  logic [SAMPLE_W-1:0] offset;
  logic [SAMPLE_W-1:0] shifted;
  logic [BIN_W-1:0]    bin;
  logic                pass;
  logic                accept;

  // room when empty or when the held request leaves this cycle
  assign in_ready = !req_valid || req_ready;
  assign accept   = in_valid && in_ready;

  // equal to the threshold still counts
  assign pass = $signed(in_sample.value) >= threshold;

  // flipping the sign bit gives offset binary
  assign offset  = {~in_sample.value[SAMPLE_W-1], in_sample.value[SAMPLE_W-2:0]};
  assign shifted = offset >> BIN_SHIFT;

  always_comb
  begin
    if (shifted > SAMPLE_W'(NUM_BINS - 1))
      bin = BIN_W'(NUM_BINS - 1);
    else
      bin = shifted[BIN_W-1:0];
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      req_valid <= 1'b0;
    end
    else if (accept)
    begin
      // samples under threshold vanish here
      req_valid <= pass;
    end
    else if (req_ready)
    begin
      req_valid <= 1'b0;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (accept && pass)
      req.bin <= bin;
  end

  a_req_hold: assert property (
    @(posedge aclk) disable iff (!aresetn)
    req_valid && !req_ready |=> req_valid && $stable(req)
  );

endmodule

`default_nettype wire

// ==== verilog/hist_pkg.sv ====
`default_nettype none

package hist_pkg;

  // detector and histogram widths
  localparam int SAMPLE_W = 16;
  localparam int BIN_W    = 6;
  localparam int NUM_BINS = 64;
  localparam int COUNT_W  = 12;

  // one signed detector sample
  typedef struct packed {
    logic signed [SAMPLE_W-1:0] value;
  } sample_t;

  // bin index handed from the binner to the accumulator
  typedef struct packed {
    logic [BIN_W-1:0] bin;
  } bin_req_t;

  // address, write data and write enable of one RAM port
  typedef struct packed {
    logic [BIN_W-1:0]   addr;
    logic [COUNT_W-1:0] wdata;
    logic               we;
  } ram_port_t;

  // one beat of a spectrum dump
  typedef struct packed {
    logic [BIN_W-1:0]   bin;
    logic [COUNT_W-1:0] count;
    logic               last;
  } bin_beat_t;

endpackage

`default_nettype wire
